/* rtl/ArithPkg.sv */
package ArithPkg;

	// word types
	typedef logic [31:0] dataT; // bus word and operand
	typedef logic [7:0]  addrT; // register byte address
	typedef logic [1:0]  respT; // axi response code

	// axi response codes
	localparam respT respOkay   = 2'd0;
	localparam respT respSlvErr = 2'd2;

	// register map
	localparam addrT regOpA    = 8'h00; // operand a, rw
	localparam addrT regOpB    = 8'h04; // operand b, rw
	localparam addrT regCtrl   = 8'h08; // write launches an operation
	localparam addrT regResult = 8'h0C; // sum of last operation
	localparam addrT regStatus = 8'h10; // carry flag in bit 0

	// control word fields
	localparam int ctrlSubBit   = 0; // subtract
	localparam int ctrlChainBit = 1; // carry in from stored flag

endpackage

/* rtl/AddIf.sv */
`timescale 1ns/100ps

interface AddIf;

	logic           start;    // launch pulse
	ArithPkg::dataT opA;
	ArithPkg::dataT opB;
	logic           subtract; // invert b
	logic           chain;    // use stored carry
	logic           done;     // result valid pulse
	ArithPkg::dataT sum;      // held until next done
	logic           carry;    // stored carry flag

	// control side launches, datapath side answers
	modport ctrl (
		output start, opA, opB, subtract, chain,
		input  done, sum, carry
	);

	modport dp (
		input  start, opA, opB, subtract, chain,
		output done, sum, carry
	);

endinterface

/* rtl/PrefixAndOr.sv */
`timescale 1ns/100ps

module PrefixAndOr #(
	parameter int speed = 1 // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  ArithPkg::dataT GI, // generate in
	input  ArithPkg::dataT PI, // propagate in
	output ArithPkg::dataT GO, // group generate out
	output ArithPkg::dataT PO  // group propagate out
);

	localparam int n = $bits(ArithPkg::dataT); // prefix width
	localparam int m = $clog2(n);              // tree depth

	if (speed == 2) begin : fastPrefix
		// sklansky, log depth, fanout doubles per level
		ArithPkg::dataT gT [0:m];
		ArithPkg::dataT pT [0:m];

		assign gT[0] = GI;
		assign pT[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar i = 0; i < n; i++) begin : bits
				if (((i >> (l - 1)) & 1) == 1) begin : black
					// top bit of the lower half block
					localparam int src = ((i >> (l - 1)) << (l - 1)) - 1;
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][src]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][src];
				end else begin : white
					assign gT[l][i] = gT[l-1][i]; // pass through
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == 1) begin : mediumPrefix
		// brent-kung, up-sweep of m levels then down-sweep of m-1 levels
		ArithPkg::dataT gT [0:2*m-1];
		ArithPkg::dataT pT [0:2*m-1];

		assign gT[0] = GI;
		assign pT[0] = PI;

		for (genvar l = 1; l < 2 * m; l++) begin : levels
			// span between a node and its partner
			localparam int d = (l <= m) ? 2 ** (l - 1) : 2 ** (2 * m - l - 1);
			for (genvar i = 0; i < n; i++) begin : bits
				localparam bit upNode   = (l <= m) && (((i + 1) % (2 * d)) == 0);
				localparam bit downNode = (l > m) && (((i + 1) % (2 * d)) == d) && (i >= 2 * d);
				if (upNode || downNode) begin : black
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][i-d]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][i-d];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else if (speed == 0) begin : slowPrefix
		// ripple chain, n-1 levels deep
		ArithPkg::dataT gT;
		ArithPkg::dataT pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];

		for (genvar i = 1; i < n; i++) begin : bits
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);
			assign pT[i] = PI[i] & pT[i-1];
		end

		assign GO = gT;
		assign PO = pT;
	end else begin : badSpeed
		$error("PrefixAndOr speed must be 0, 1 or 2");
	end

endmodule

/* rtl/AddC.sv */
`timescale 1ns/100ps

module AddC #(
	parameter int speed = 1 // prefix structure
) (
	input  ArithPkg::dataT A,  // operands
	input  ArithPkg::dataT B,
	input  logic           CI, // carry in
	output ArithPkg::dataT S,  // sum
	output logic           CO  // carry out
);

	localparam int n = $bits(ArithPkg::dataT);

	ArithPkg::dataT gIn;  // prefix generate in
	ArithPkg::dataT pIn;  // prefix propagate in
	ArithPkg::dataT gOut; // carries out of each bit
	ArithPkg::dataT pT;   // half sum, a xor b

	// bit 0 folds the carry in into its generate
	assign gIn[0] = (A[0] & B[0]) | (A[0] & CI) | (B[0] & CI);
	assign pIn[0] = 1'b0; // nothing propagates below bit 0
	assign pT[0]  = A[0] ^ B[0];

	for (genvar i = 1; i < n; i++) begin : preprocess
		assign gIn[i] = A[i] & B[i];
		assign pIn[i] = A[i] | B[i];
		assign pT[i]  = ~gIn[i] & pIn[i]; // same as xor
	end

	// group propagate unused, pIn[0] is zero
	PrefixAndOr #(.speed(speed)) prefix_i (
		.GI(gIn),
		.PI(pIn),
		.GO(gOut),
		.PO()
	);

	assign S  = pT ^ {gOut[n-2:0], CI}; // carry into bit i is gOut[i-1]
	assign CO = gOut[n-1];

endmodule

/* rtl/AddDatapath.sv */
`timescale 1ns/100ps

module AddDatapath #(
	parameter int speed = 1 // prefix structure of the adder
) (
	input logic clk,
	input logic reset,
	AddIf.dp    bus
);

	ArithPkg::dataT bIn;    // b after conditioning
	logic           cIn;    // selected carry in
	ArithPkg::dataT sum;    // adder out
	logic           cOut;
	logic [32:0]    refSum; // plain add of the same inputs

	assign bIn = bus.subtract ? ~bus.opB : bus.opB; // ones complement for subtract

	// chain wins over subtract, so sub with chain is subtract with borrow
	always_comb begin
		if (bus.chain)
			cIn = bus.carry;
		else if (bus.subtract)
			cIn = 1'b1; // completes two's complement
		else
			cIn = 1'b0;
	end

	AddC #(.speed(speed)) AddC_i (
		.A(bus.opA),
		.B(bIn),
		.CI(cIn),
		.S(sum),
		.CO(cOut)
	);

	assign refSum = {1'b0, bus.opA} + {1'b0, bIn} + 33'(cIn);

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.sum   <= '0;
			bus.carry <= 1'b0; // stored flag for chaining
			bus.done  <= 1'b0;
		end else begin
			bus.done <= bus.start; // one cycle after start
			if (bus.start) begin
				bus.sum   <= sum;
				bus.carry <= cOut;
			end
		end
	end

	// result only for a launched operation, and equal to a plain add
	assert property (@(posedge clk) disable iff (reset)
		bus.done |-> $past(bus.start) && ({bus.carry, bus.sum} == $past(refSum)))
		else $error("done without start or wrong sum from the prefix adder");

endmodule

/* rtl/AddCtrl.sv */
`timescale 1ns/100ps

module AddCtrl (
	input  logic           clk,
	input  logic           reset,
	input  ArithPkg::addrT AWADDR,
	input  logic           AWVALID,
	output logic           AWREADY,
	input  ArithPkg::dataT WDATA,
	input  logic           WVALID,
	output logic           WREADY,
	output ArithPkg::respT BRESP,
	output logic           BVALID,
	input  logic           BREADY,
	input  ArithPkg::addrT ARADDR,
	input  logic           ARVALID,
	output logic           ARREADY,
	output ArithPkg::dataT RDATA,
	output ArithPkg::respT RRESP,
	output logic           RVALID,
	input  logic           RREADY,
	AddIf.ctrl             bus
);

	typedef enum logic [1:0] {idle, busy, respond} writeStateT;

	writeStateT     writeState;
	logic           wrAccept; // aw and w transfer this cycle
	logic           rdAccept;
	logic           wrMapped; // write hits a register
	ArithPkg::dataT rdData;   // read mux
	ArithPkg::respT rdResp;

	assign wrAccept = AWVALID & AWREADY & WVALID & WREADY;
	assign rdAccept = ARVALID & ARREADY;
	assign wrMapped = AWADDR inside {ArithPkg::regOpA, ArithPkg::regOpB, ArithPkg::regCtrl,
		ArithPkg::regResult, ArithPkg::regStatus};

	always_ff @(posedge clk) begin
		if (reset) begin
			writeState   <= idle;
			AWREADY      <= 1'b0;
			WREADY       <= 1'b0;
			BVALID       <= 1'b0;
			bus.start    <= 1'b0;
			bus.opA      <= '0;
			bus.opB      <= '0;
			bus.subtract <= 1'b0;
			bus.chain    <= 1'b0;
		end else begin
			bus.start <= 1'b0; // pulse
			case (writeState)
				idle: begin
					// ready for one cycle, drops again on the transfer
					AWREADY <= AWVALID & WVALID & ~AWREADY;
					WREADY  <= AWVALID & WVALID & ~AWREADY;
					if (wrAccept) begin
						case (AWADDR)
							ArithPkg::regOpA: bus.opA <= WDATA;
							ArithPkg::regOpB: bus.opB <= WDATA;
							ArithPkg::regCtrl: begin
								bus.subtract <= WDATA[ArithPkg::ctrlSubBit];
								bus.chain    <= WDATA[ArithPkg::ctrlChainBit];
								bus.start    <= 1'b1; // launch
							end
							default: ; // result and status are read only
						endcase
						// ctrl write holds B until the datapath is done
						writeState <= (AWADDR == ArithPkg::regCtrl) ? busy : respond;
						BVALID     <= (AWADDR != ArithPkg::regCtrl);
					end
				end
				busy: if (bus.done) begin
					BVALID     <= 1'b1;
					writeState <= respond;
				end
				respond: if (BREADY) begin
					BVALID     <= 1'b0; // held under back-pressure
					writeState <= idle;
				end
				default: writeState <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept)
			BRESP <= wrMapped ? ArithPkg::respOkay : ArithPkg::respSlvErr;
	end

	// read mux
	always_comb begin
		rdData = '0;
		rdResp = ArithPkg::respOkay;
		case (ARADDR)
			ArithPkg::regOpA: rdData = bus.opA;
			ArithPkg::regOpB: rdData = bus.opB;
			ArithPkg::regCtrl: begin
				rdData[ArithPkg::ctrlSubBit]   = bus.subtract;
				rdData[ArithPkg::ctrlChainBit] = bus.chain;
			end
			ArithPkg::regResult: rdData = bus.sum;
			ArithPkg::regStatus: rdData[0] = bus.carry;
			default: rdResp = ArithPkg::respSlvErr; // zero data
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ARREADY <= 1'b0;
			RVALID  <= 1'b0;
		end else begin
			ARREADY <= ARVALID & ~ARREADY & ~RVALID; // no new read while R pending
			if (rdAccept)
				RVALID <= 1'b1;
			else if (RREADY)
				RVALID <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rdAccept) begin
			RDATA <= rdData;
			RRESP <= rdResp;
		end
	end

	// a launched operation is answered by done next cycle, with no second start before it
	assert property (@(posedge clk) disable iff (reset)
		bus.start |=> bus.done && !bus.start)
		else $error("start raised during a running operation");

	assert property (@(posedge clk) disable iff (reset)
		BVALID && !BREADY |=> BVALID && $stable(BRESP))
		else $error("write response dropped before BREADY");

endmodule

/* rtl/AddUnit.sv */
`timescale 1ns/100ps

module AddUnit #(
	parameter int speed = 1 // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic           clk,
	input  logic           reset,
	input  ArithPkg::addrT AWADDR,
	input  logic           AWVALID,
	output logic           AWREADY,
	input  ArithPkg::dataT WDATA,
	input  logic           WVALID,
	output logic           WREADY,
	output ArithPkg::respT BRESP,
	output logic           BVALID,
	input  logic           BREADY,
	input  ArithPkg::addrT ARADDR,
	input  logic           ARVALID,
	output logic           ARREADY,
	output ArithPkg::dataT RDATA,
	output ArithPkg::respT RRESP,
	output logic           RVALID,
	input  logic           RREADY
);

	AddIf addBus (); // launch and result handshake

	AddCtrl AddCtrl_i (
		.clk(clk),
		.reset(reset),
		.AWADDR(AWADDR),
		.AWVALID(AWVALID),
		.AWREADY(AWREADY),
		.WDATA(WDATA),
		.WVALID(WVALID),
		.WREADY(WREADY),
		.BRESP(BRESP),
		.BVALID(BVALID),
		.BREADY(BREADY),
		.ARADDR(ARADDR),
		.ARVALID(ARVALID),
		.ARREADY(ARREADY),
		.RDATA(RDATA),
		.RRESP(RRESP),
		.RVALID(RVALID),
		.RREADY(RREADY),
		.bus(addBus.ctrl)
	);

	AddDatapath #(.speed(speed)) AddDatapath_i (
		.clk(clk),
		.reset(reset),
		.bus(addBus.dp)
	);

endmodule

/* tests/AddUnitTb.sv */
`timescale 1ns/100ps

module AddUnitTb #(
	parameter int speed = 1 // prefix structure under test
);

	localparam int numHand   = 10;
	localparam int numRandom = 14;
	localparam int numRows   = numHand + numRandom;
	localparam int watchdogCycles = (numRows + 10) * 60; // extra rows cover reset and unmapped tests

	typedef struct {
		string          name;
		ArithPkg::dataT opA;
		ArithPkg::dataT opB;
		logic           subtract;
		logic           chain;
		ArithPkg::dataT expSum;
		logic           expCarry;
	} rowT;

	logic           clk;
	logic           reset;
	ArithPkg::addrT AWADDR;
	logic           AWVALID;
	logic           AWREADY;
	ArithPkg::dataT WDATA;
	logic           WVALID;
	logic           WREADY;
	ArithPkg::respT BRESP;
	logic           BVALID;
	logic           BREADY;
	ArithPkg::addrT ARADDR;
	logic           ARVALID;
	logic           ARREADY;
	ArithPkg::dataT RDATA;
	ArithPkg::respT RRESP;
	logic           RVALID;
	logic           RREADY;

	rowT         rows [$];
	int          errorCount = 0;
	int          checkCount = 0;
	logic [31:0] lcgState = 32'hfc33f9e7;

	AddUnit #(.speed(speed)) AddUnit_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// compare and report, counts every call
	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223; // numerical recipes constants
		return lcgState;
	endfunction

	// 33 bit reference, carry in rule: chain takes stored flag, else subtract forces 1
	function automatic logic [32:0] refAdd(input ArithPkg::dataT a, input ArithPkg::dataT b,
		input logic sub, input logic chain, input logic stored);
		logic [32:0] bExt;
		logic        cIn;
		bExt = {1'b0, sub ? ~b : b};
		cIn  = chain ? stored : sub;
		return {1'b0, a} + bExt + {32'b0, cIn};
	endfunction

	task automatic addRow(input string name, input ArithPkg::dataT a, input ArithPkg::dataT b,
		input logic sub, input logic chain, input ArithPkg::dataT sum, input logic carry);
		rowT r;
		r.name     = name;
		r.opA      = a;
		r.opB      = b;
		r.subtract = sub;
		r.chain    = chain;
		r.expSum   = sum;
		r.expCarry = carry;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		logic        stored;
		logic [32:0] ref33;
		ArithPkg::dataT a;
		ArithPkg::dataT b;
		logic [31:0] mode;
		addRow("add small", 32'h5, 32'h7, 1'b0, 1'b0, 32'hc, 1'b0);
		addRow("ones plus one", 32'hffffffff, 32'h1, 1'b0, 1'b0, 32'h0, 1'b1);
		addRow("add max", 32'hffffffff, 32'hffffffff, 1'b0, 1'b0, 32'hfffffffe, 1'b1);
		addRow("sub a above b", 32'h10, 32'h3, 1'b1, 1'b0, 32'hd, 1'b1);
		addRow("sub a below b", 32'h3, 32'h10, 1'b1, 1'b0, 32'hfffffff3, 1'b0);
		addRow("sub equal", 32'h1234, 32'h1234, 1'b1, 1'b0, 32'h0, 1'b1);
		// 0x1_fffffff0 + 0x2_00000020 = 0x4_00000010
		addRow("add64 low", 32'hfffffff0, 32'h20, 1'b0, 1'b0, 32'h10, 1'b1);
		addRow("add64 high", 32'h1, 32'h2, 1'b0, 1'b1, 32'h4, 1'b0);
		// 0x5_00000001 - 0x2_00000003 = 0x2_fffffffe
		addRow("sub64 low", 32'h1, 32'h3, 1'b1, 1'b0, 32'hfffffffe, 1'b0);
		addRow("sub64 high", 32'h5, 32'h2, 1'b1, 1'b1, 32'h2, 1'b1);
		stored = 1'b1; // carry left by the last hand row
		for (int k = 0; k < numRandom; k++) begin
			a     = nextRandom();
			b     = nextRandom();
			mode  = nextRandom(); // top bits, lcg low bits are weak
			ref33 = refAdd(a, b, mode[31], mode[30], stored);
			addRow($sformatf("random %0d", k), a, b, mode[31], mode[30], ref33[31:0], ref33[32]);
			stored = ref33[32];
		end
	endtask

	// one write, B held off for stall cycles once valid
	task automatic axiWrite(input ArithPkg::addrT addr, input ArithPkg::dataT data,
		input int stall, output ArithPkg::respT resp);
		AWADDR  = addr;
		AWVALID = 1'b1;
		WDATA   = data;
		WVALID  = 1'b1;
		do @(negedge clk); while (!AWREADY && !WREADY); // ready seen, transfer at next edge
		checkValue("wready with awready", 32'(AWREADY), 32'(WREADY));
		@(negedge clk);
		AWVALID = 1'b0;
		WVALID  = 1'b0;
		while (!BVALID) @(negedge clk);
		resp = BRESP;
		repeat (stall) begin
			@(negedge clk);
			checkValue("bvalid under back-pressure", 32'd1, 32'(BVALID));
			checkValue("bresp under back-pressure", 32'(resp), 32'(BRESP));
		end
		BREADY = 1'b1;
		@(negedge clk);
		BREADY = 1'b0;
	endtask

	task automatic axiRead(input ArithPkg::addrT addr, input int stall,
		output ArithPkg::dataT data, output ArithPkg::respT resp);
		ARADDR  = addr;
		ARVALID = 1'b1;
		do @(negedge clk); while (!ARREADY);
		@(negedge clk);
		ARVALID = 1'b0;
		while (!RVALID) @(negedge clk);
		data = RDATA;
		resp = RRESP;
		repeat (stall) begin
			@(negedge clk);
			checkValue("rvalid under back-pressure", 32'd1, 32'(RVALID));
			checkValue("rdata under back-pressure", data, RDATA);
		end
		RREADY = 1'b1;
		@(negedge clk);
		RREADY = 1'b0;
	endtask

	initial begin
		ArithPkg::dataT data;
		ArithPkg::respT resp;
		logic [31:0]    ctrlWord;
		int             stall;
		reset   = 1'b1;
		AWADDR  = '0;
		AWVALID = 1'b0;
		WDATA   = '0;
		WVALID  = 1'b0;
		BREADY  = 1'b0;
		ARADDR  = '0;
		ARVALID = 1'b0;
		RREADY  = 1'b0;
		buildTable();
		repeat (2) @(negedge clk); // two rising edges in reset
		reset = 1'b0;

		axiRead(ArithPkg::regResult, 0, data, resp);
		checkValue("reset result", 32'h0, data);
		checkValue("reset result rresp", 32'(ArithPkg::respOkay), 32'(resp));
		axiRead(ArithPkg::regStatus, 0, data, resp);
		checkValue("reset status", 32'h0, data);
		checkValue("reset status rresp", 32'(ArithPkg::respOkay), 32'(resp));

		foreach (rows[i]) begin
			stall    = i % 3; // back-pressure on every third row pattern
			ctrlWord = '0;
			ctrlWord[ArithPkg::ctrlSubBit]   = rows[i].subtract;
			ctrlWord[ArithPkg::ctrlChainBit] = rows[i].chain;
			axiWrite(ArithPkg::regOpA, rows[i].opA, 0, resp);
			checkValue({rows[i].name, " opA bresp"}, 32'(ArithPkg::respOkay), 32'(resp));
			axiWrite(ArithPkg::regOpB, rows[i].opB, 0, resp);
			checkValue({rows[i].name, " opB bresp"}, 32'(ArithPkg::respOkay), 32'(resp));
			axiWrite(ArithPkg::regCtrl, ctrlWord, stall, resp); // returns after done
			checkValue({rows[i].name, " ctrl bresp"}, 32'(ArithPkg::respOkay), 32'(resp));
			axiRead(ArithPkg::regOpA, 0, data, resp);
			checkValue({rows[i].name, " opA readback"}, rows[i].opA, data);
			axiRead(ArithPkg::regOpB, 0, data, resp);
			checkValue({rows[i].name, " opB readback"}, rows[i].opB, data);
			axiRead(ArithPkg::regResult, stall, data, resp);
			checkValue({rows[i].name, " sum"}, rows[i].expSum, data);
			checkValue({rows[i].name, " sum rresp"}, 32'(ArithPkg::respOkay), 32'(resp));
			axiRead(ArithPkg::regStatus, stall, data, resp);
			checkValue({rows[i].name, " carry"}, {31'b0, rows[i].expCarry}, data);
		end

		// unmapped space
		axiWrite(8'h20, 32'hdeadbeef, 2, resp);
		checkValue("unmapped write bresp", 32'(ArithPkg::respSlvErr), 32'(resp));
		axiRead(8'h20, 0, data, resp);
		checkValue("unmapped read data", 32'h0, data);
		checkValue("unmapped read rresp", 32'(ArithPkg::respSlvErr), 32'(resp));
		axiRead(8'h14, 3, data, resp);
		checkValue("unmapped read 0x14 data", 32'h0, data);
		checkValue("unmapped read 0x14 rresp", 32'(ArithPkg::respSlvErr), 32'(resp));

		$display("Checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: the test did not finish within %0d cycles", watchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* AddUnit.f */
rtl/ArithPkg.sv
rtl/AddIf.sv
rtl/PrefixAndOr.sv
rtl/AddC.sv
rtl/AddDatapath.sv
rtl/AddCtrl.sv
rtl/AddUnit.sv
tests/AddUnitTb.sv

/* Makefile */
SPEED     ?= 1
VERILATOR ?= verilator
TOP       ?= AddUnitTb
FILELIST  ?= AddUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Gspeed=$(SPEED) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
